/* verilog/bru_defines.svh */
/*
  Build-time constants for the branch resolution slice.
  The global history must not be wider than the predictor index.
  RV32I only, so every instruction is 4 bytes long.
*/

`ifndef BRU_DEFINES_SVH
`define BRU_DEFINES_SVH

`default_nettype none

// Data and PC width
`define BRU_XLEN 32
// Global history length in branches
`define BRU_GHIST_BITS 2
// Predictor index width, 64 counters
`define BRU_BHT_IDX_BITS 6
// Next PC after reset
`define BRU_PC_INIT 32'h0000_0200

`default_nettype wire

`endif

/* verilog/bru_pkg.sv */
/*
  Types, opcode constants and the branch class used by the branch unit.
  Only the RV32I opcodes that the branch unit resolves are listed.
*/

`include "bru_defines.svh"

`default_nettype none

package bru_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [`BRU_XLEN-1:0]         xlen_t;
  typedef logic [31:0]                  insn_t;
  // Bit 1 set means predict taken
  typedef logic [1:0]                   bp_cnt_t;
  typedef logic [`BRU_GHIST_BITS-1:0]   ghist_t;
  typedef logic [`BRU_BHT_IDX_BITS-1:0] bht_idx_t;

  // Bits 0..3 are access fault, illegal, misaligned, breakpoint
  typedef logic [3:0]                   exc_t;

  localparam int unsigned EXC_MISALIGNED_BIT = 2;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  // FENCE.I within MISC-MEM
  localparam logic [2:0] F3_FENCE_I   = 3'b001;

  // Decoded class of the instruction in execute
  typedef enum logic [3:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_FENCEI
  } br_class_e;

endpackage

`default_nettype wire

/* verilog/bru_decode.sv */
/*
  Classifies the instruction word for the branch unit.
  Purely combinational. A bubble always decodes as BR_NONE.
  JALR needs no immediate, its target comes from the operands.
*/

`default_nettype none

module bru_decode
  import bru_pkg::*;
(
  input  insn_t     insn_i,
  input  logic      bubble_i,
  output br_class_e br_class_o,
  output xlen_t     imm_o
);

  localparam int unsigned XW = $bits(xlen_t);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [20:0] imm_j;
  logic [12:0] imm_b;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // J-type and B-type immediates, bit 0 is always zero
  assign imm_j = {insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_b = {insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

  ////////////////////////////////////////////////////////////
  // Class
  ////////////////////////////////////////////////////////////

  always_comb begin
    br_class_o = BR_NONE;
    if (!bubble_i) begin
      case (opcode)
        OPC_BRANCH: begin
          case (funct3)
            3'b000:  br_class_o = BR_BEQ;
            3'b001:  br_class_o = BR_BNE;
            3'b100:  br_class_o = BR_BLT;
            3'b101:  br_class_o = BR_BGE;
            3'b110:  br_class_o = BR_BLTU;
            3'b111:  br_class_o = BR_BGEU;
            default: br_class_o = BR_NONE;
          endcase
        end
        OPC_JAL: br_class_o = BR_JAL;
        OPC_JALR: begin
          if (funct3 == 3'b000) br_class_o = BR_JALR;
        end
        OPC_MISC_MEM: begin
          // Plain FENCE is a no-op here
          if (funct3 == F3_FENCE_I) br_class_o = BR_FENCEI;
        end
        default: br_class_o = BR_NONE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Immediate
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (br_class_o)
      BR_JAL: imm_o = {{(XW-21){imm_j[20]}}, imm_j};
      BR_BEQ,
      BR_BNE,
      BR_BLT,
      BR_BGE,
      BR_BLTU,
      BR_BGEU: imm_o = {{(XW-13){imm_b[12]}}, imm_b};
      default: imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/bru_resolve.sv */
/*
  Execute-stage branch unit with a one cycle registered result.
  No return stack, so JALR always flushes the pipeline.
  Stall holds next PC and exceptions and drops every strobe.
  Kill and a previous flush clear the exceptions but not the next PC.
*/

`include "bru_defines.svh"

`default_nettype none

module bru_resolve
  import bru_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      stall_i,
  input  logic      kill_i,
  input  br_class_e br_class_i,
  input  xlen_t     imm_i,
  input  xlen_t     pc_i,
  input  xlen_t     opa_i,
  input  xlen_t     opb_i,
  input  exc_t      exc_i,
  input  bp_cnt_t   predict_i,
  input  ghist_t    lookup_hist_i,
  output xlen_t     nxt_pc_o,
  output logic      flush_o,
  output logic      ic_invalidate_o,
  output logic      dc_clean_o,
  output exc_t      exc_o,
  output logic      exc_any_o,
  output logic      bp_update_o,
  output logic      bp_taken_o,
  output bp_cnt_t   bp_predict_o,
  output ghist_t    bp_hist_o,
  output ghist_t    ghist_o
);

  localparam int unsigned GH = `BRU_GHIST_BITS;

  logic        is_cond;
  logic        is_xfer;
  logic        btaken;
  logic        pipe_flush;
  logic        ic_inv;
  logic        dc_cln;
  logic        misaligned;
  logic        op_eq;
  logic        op_lt_s;
  logic        op_lt_u;
  xlen_t       pc_seq;
  xlen_t       pc_rel;
  xlen_t       jalr_tgt;
  xlen_t       nxt_pc;
  exc_t        exc_nxt;
  logic [GH:0] ghist_q;

  assign pc_seq   = pc_i + xlen_t'(4);
  assign pc_rel   = pc_i + imm_i;
  assign jalr_tgt = (opa_i + opb_i) & ~xlen_t'(1);

  assign op_eq   = (opa_i == opb_i);
  assign op_lt_s = ($signed(opa_i) < $signed(opb_i));
  assign op_lt_u = (opa_i < opb_i);

  ////////////////////////////////////////////////////////////
  // Resolution
  ////////////////////////////////////////////////////////////

  always_comb begin
    is_cond    = 1'b0;
    btaken     = 1'b0;
    pipe_flush = 1'b0;
    ic_inv     = 1'b0;
    dc_cln     = 1'b0;
    nxt_pc     = pc_seq;
    case (br_class_i)
      BR_BEQ: begin
        is_cond = 1'b1;
        btaken  = op_eq;
      end
      BR_BNE: begin
        is_cond = 1'b1;
        btaken  = ~op_eq;
      end
      BR_BLT: begin
        is_cond = 1'b1;
        btaken  = op_lt_s;
      end
      BR_BGE: begin
        is_cond = 1'b1;
        btaken  = ~op_lt_s;
      end
      BR_BLTU: begin
        is_cond = 1'b1;
        btaken  = op_lt_u;
      end
      BR_BGEU: begin
        is_cond = 1'b1;
        btaken  = ~op_lt_u;
      end
      BR_JAL: begin
        // Fetch already followed a taken prediction
        btaken     = 1'b1;
        pipe_flush = ~predict_i[1];
        nxt_pc     = pc_rel;
      end
      BR_JALR: begin
        btaken     = 1'b1;
        pipe_flush = 1'b1;
        nxt_pc     = jalr_tgt;
      end
      BR_FENCEI: begin
        pipe_flush = 1'b1;
        ic_inv     = 1'b1;
        dc_cln     = 1'b1;
      end
      default: begin
        btaken = 1'b0;
      end
    endcase

    // Mispredicted conditional branches restart fetch
    if (is_cond) begin
      pipe_flush = btaken ^ predict_i[1];
      if (btaken) nxt_pc = pc_rel;
    end
  end

  // Targets must be word aligned without RVC
  assign is_xfer    = is_cond | (br_class_i == BR_JAL) | (br_class_i == BR_JALR);
  assign misaligned = exc_i[EXC_MISALIGNED_BIT] | (is_xfer & (|nxt_pc[1:0]));

  always_comb begin
    exc_nxt                     = exc_i;
    exc_nxt[EXC_MISALIGNED_BIT] = misaligned;
  end

  ////////////////////////////////////////////////////////////
  // Registered results
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nxt_pc_o <= `BRU_PC_INIT;
      exc_o    <= '0;
    end else if (!stall_i) begin
      nxt_pc_o <= nxt_pc;
      if (kill_i || flush_o) begin
        exc_o <= '0;
      end else begin
        exc_o <= exc_nxt;
      end
    end
  end

  assign exc_any_o = |exc_o;

  // Flush out of reset forces the first fetch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o         <= 1'b1;
      ic_invalidate_o <= 1'b0;
      dc_clean_o      <= 1'b0;
      bp_update_o     <= 1'b0;
    end else if (stall_i) begin
      flush_o         <= 1'b0;
      ic_invalidate_o <= 1'b0;
      dc_clean_o      <= 1'b0;
      bp_update_o     <= 1'b0;
    end else begin
      flush_o         <= pipe_flush;
      ic_invalidate_o <= ic_inv;
      dc_clean_o      <= dc_cln;
      bp_update_o     <= is_cond;
    end
  end

  // Training data is only used while bp_update_o is high
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      bp_taken_o   <= btaken;
      bp_predict_o <= predict_i;
      bp_hist_o    <= lookup_hist_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Global history
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ghist_q <= '0;
    end else if (!stall_i && is_cond) begin
      ghist_q <= {ghist_q[GH-1:0], btaken};
    end
  end

  // Newest bit belongs to the branch still being trained
  assign ghist_o = ghist_q[GH:1];

endmodule

`default_nettype wire

/* verilog/bru_predictor.sv */
/*
  Global-history predictor of 2-bit saturating counters.
  Index is pc[IDX+1:2] XOR history, history zero-extended to the index.
  A write lands on the edge after the update cycle, so a same-index
  lookup in that cycle still returns the old counter.
*/

`include "bru_defines.svh"

`default_nettype none

module bru_predictor
  import bru_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    stall_i,
  input  xlen_t   pc_i,
  input  ghist_t  ghist_i,
  output bp_cnt_t predict_o,
  output ghist_t  lookup_hist_o,
  input  logic    update_i,
  input  logic    taken_i,
  input  bp_cnt_t old_cnt_i,
  input  ghist_t  upd_hist_i
);

  localparam int unsigned IDX      = `BRU_BHT_IDX_BITS;
  localparam int unsigned BHT_SIZE = 1 << IDX;

  bp_cnt_t  cnt_q [BHT_SIZE];
  bht_idx_t pc_idx;
  bht_idx_t lookup_idx;
  bht_idx_t pc_idx_q;
  bht_idx_t upd_idx;

  // One step toward the outcome, saturating at both ends
  function automatic bp_cnt_t cnt_step(bp_cnt_t cnt, logic taken);
    bp_cnt_t res;
    res = cnt;
    if (taken) begin
      if (cnt != 2'b11) res = cnt + 2'b01;
    end else begin
      if (cnt != 2'b00) res = cnt - 2'b01;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  // Bits 1:0 carry no information for 4-byte instructions
  assign pc_idx     = pc_i[IDX+1:2];
  assign lookup_idx = pc_idx ^ bht_idx_t'(ghist_i);

  assign predict_o     = cnt_q[lookup_idx];
  assign lookup_hist_o = ghist_i;

  // PC part of the index for the instruction now in execute
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_idx_q <= pc_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////

  assign upd_idx = pc_idx_q ^ bht_idx_t'(upd_hist_i);

  // All counters start weakly not taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_SIZE; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (update_i) begin
      cnt_q[upd_idx] <= cnt_step(old_cnt_i, taken_i);
    end
  end

endmodule

`default_nettype wire

/* verilog/bru_top.sv */
/*
  Branch resolution slice of an in-order RV32I core.
  Results appear one cycle after the instruction is presented.
  predict_o is the counter for the pc_i of the current cycle.
*/

`default_nettype none

module bru_top
  import bru_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    stall_i,
  input  logic    kill_i,
  input  xlen_t   pc_i,
  input  insn_t   insn_i,
  input  logic    bubble_i,
  input  xlen_t   opa_i,
  input  xlen_t   opb_i,
  input  exc_t    exc_i,
  output xlen_t   nxt_pc_o,
  output logic    flush_o,
  output logic    ic_invalidate_o,
  output logic    dc_clean_o,
  output exc_t    exc_o,
  output logic    exc_any_o,
  output bp_cnt_t predict_o
);

  br_class_e br_class;
  xlen_t     imm;
  ghist_t    lookup_hist;
  ghist_t    ghist;
  logic      bp_update;
  logic      bp_taken;
  bp_cnt_t   bp_predict;
  ghist_t    bp_hist;

  bru_decode u_decode (
    .insn_i     (insn_i),
    .bubble_i   (bubble_i),
    .br_class_o (br_class),
    .imm_o      (imm)
  );

  bru_resolve u_resolve (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_i),
    .kill_i          (kill_i),
    .br_class_i      (br_class),
    .imm_i           (imm),
    .pc_i            (pc_i),
    .opa_i           (opa_i),
    .opb_i           (opb_i),
    .exc_i           (exc_i),
    .predict_i       (predict_o),
    .lookup_hist_i   (lookup_hist),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .ic_invalidate_o (ic_invalidate_o),
    .dc_clean_o      (dc_clean_o),
    .exc_o           (exc_o),
    .exc_any_o       (exc_any_o),
    .bp_update_o     (bp_update),
    .bp_taken_o      (bp_taken),
    .bp_predict_o    (bp_predict),
    .bp_hist_o       (bp_hist),
    .ghist_o         (ghist)
  );

  bru_predictor u_predictor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_i),
    .pc_i          (pc_i),
    .ghist_i       (ghist),
    .predict_o     (predict_o),
    .lookup_hist_o (lookup_hist),
    .update_i      (bp_update),
    .taken_i       (bp_taken),
    .old_cnt_i     (bp_predict),
    .upd_hist_i    (bp_hist)
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
/*
  Testbench clock with an 8-unit period, first rising edge at 4.
  Reset is low from time zero for three cycles and rises on a falling edge.
*/

`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/tb_bru_top.sv */
/*
  Random testbench for bru_top with a cycle model of the branch unit.
  Inputs change 1 unit after the rising edge. Registered outputs are
  checked just after the edge, predict_o at the falling edge.
  PCs come from a small pool so that predictor entries are revisited.
*/

`include "bru_defines.svh"

`default_nettype none

module tb_bru_top
  import bru_pkg::*;
();

  localparam int unsigned NUM_CYCLES  = 2000;
  localparam int unsigned CYCLE_LIMIT = NUM_CYCLES + 100;
  localparam int unsigned BHT_SIZE    = 1 << `BRU_BHT_IDX_BITS;

  logic    clk;
  logic    rst_n;
  logic    stall;
  logic    kill;
  xlen_t   pc;
  insn_t   insn;
  logic    bubble;
  xlen_t   opa;
  xlen_t   opb;
  exc_t    exc_in;
  xlen_t   nxt_pc;
  logic    flush;
  logic    ic_inv;
  logic    dc_clean;
  exc_t    exc_out;
  logic    exc_any;
  bp_cnt_t predict;

  // Stimulus as the testbench meant it
  br_class_e cls;
  xlen_t     imm_s;
  xlen_t     pc_pool [8];

  // Model state
  bp_cnt_t                 bht_m [BHT_SIZE];
  logic [`BRU_GHIST_BITS:0] hist_m;
  logic                    upd_pend;
  bht_idx_t                upd_idx_m;
  logic                    upd_taken_m;
  bp_cnt_t                 upd_cnt_m;
  xlen_t                   nxt_pc_m;
  logic                    flush_m;
  logic                    ic_m;
  logic                    dc_m;
  exc_t                    exc_m;

  integer      seed;
  int unsigned cycles;
  int unsigned value_errs;
  int unsigned other_errs;
  logic        sat_hi_seen;
  logic        sat_lo_seen;
  logic        fencei_seen;
  logic        mis_seen;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  bru_top uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .stall_i         (stall),
    .kill_i          (kill),
    .pc_i            (pc),
    .insn_i          (insn),
    .bubble_i        (bubble),
    .opa_i           (opa),
    .opb_i           (opb),
    .exc_i           (exc_in),
    .nxt_pc_o        (nxt_pc),
    .flush_o         (flush),
    .ic_invalidate_o (ic_inv),
    .dc_clean_o      (dc_clean),
    .exc_o           (exc_out),
    .exc_any_o       (exc_any),
    .predict_o       (predict)
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic test_exc(input string name, input exc_t exp, input exc_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic verify_counter(input string name, input bp_cnt_t exp, input bp_cnt_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic expect_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic outputs_vs_model();
    check_word("nxt_pc_o", nxt_pc_m, nxt_pc);
    expect_bit("flush_o", flush_m, flush);
    expect_bit("ic_invalidate_o", ic_m, ic_inv);
    expect_bit("dc_clean_o", dc_m, dc_clean);
    test_exc("exc_o", exc_m, exc_out);
    expect_bit("exc_any_o", |exc_m, exc_any);
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction encoding and counter rule
  ////////////////////////////////////////////////////////////

  function automatic insn_t branch_insn(logic [2:0] f3, logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic insn_t jal_insn(logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
  endfunction

  // Two-bit counter moved one step toward the outcome
  function automatic bp_cnt_t trained(bp_cnt_t cnt, logic taken);
    bp_cnt_t res;
    res = cnt;
    if (taken && cnt != 2'b11) begin
      res = cnt + 2'b01;
    end else if (!taken && cnt != 2'b00) begin
      res = cnt - 2'b01;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////

  task automatic reset_model();
    for (int i = 0; i < BHT_SIZE; i++) begin
      bht_m[i] = 2'b01;
    end
    hist_m   = '0;
    upd_pend = 1'b0;
    nxt_pc_m = `BRU_PC_INIT;
    flush_m  = 1'b1;
    ic_m     = 1'b0;
    dc_m     = 1'b0;
    exc_m    = '0;
  endtask

  // Checks the lookup of this cycle, then steps the model over the next edge
  task automatic advance_model();
    bht_idx_t idx;
    bp_cnt_t  pred;
    logic     cond;
    logic     taken;
    logic     redirect;
    logic     xfer;
    xlen_t    target;
    exc_t     exc_new;
    idx  = pc[`BRU_BHT_IDX_BITS+1:2] ^ bht_idx_t'(hist_m[`BRU_GHIST_BITS:1]);
    pred = bht_m[idx];
    verify_counter("predict_o", pred, predict);
    if (pred == 2'b11) sat_hi_seen = 1'b1;
    if (pred == 2'b00) sat_lo_seen = 1'b1;
    cond     = 1'b1;
    taken    = 1'b0;
    redirect = 1'b0;
    target   = pc + 32'd4;
    case (cls)
      BR_BEQ:  taken = (opa == opb);
      BR_BNE:  taken = (opa != opb);
      BR_BLT:  taken = ($signed(opa) < $signed(opb));
      BR_BGE:  taken = ($signed(opa) >= $signed(opb));
      BR_BLTU: taken = (opa < opb);
      BR_BGEU: taken = (opa >= opb);
      default: cond = 1'b0;
    endcase
    if (cond) begin
      redirect = taken ^ pred[1];
      if (taken) target = pc + imm_s;
    end
    xfer = cond;
    if (cls == BR_JAL) begin
      target   = pc + imm_s;
      redirect = ~pred[1];
      xfer     = 1'b1;
    end else if (cls == BR_JALR) begin
      target   = (opa + opb) & 32'hffff_fffe;
      redirect = 1'b1;
      xfer     = 1'b1;
    end else if (cls == BR_FENCEI) begin
      redirect = 1'b1;
    end
    exc_new                     = exc_in;
    exc_new[EXC_MISALIGNED_BIT] = exc_in[EXC_MISALIGNED_BIT] | (xfer & (|target[1:0]));

    // Training from the previous instruction lands on this edge
    if (upd_pend) bht_m[upd_idx_m] = trained(upd_cnt_m, upd_taken_m);
    if (stall) begin
      upd_pend = 1'b0;
      flush_m  = 1'b0;
      ic_m     = 1'b0;
      dc_m     = 1'b0;
    end else begin
      if (xfer && (|target[1:0])) mis_seen = 1'b1;
      if (cls == BR_FENCEI) fencei_seen = 1'b1;
      upd_pend    = cond;
      upd_idx_m   = idx;
      upd_cnt_m   = pred;
      upd_taken_m = taken;
      if (cond) hist_m = {hist_m[`BRU_GHIST_BITS-1:0], taken};
      exc_m    = (kill || flush_m) ? 4'h0 : exc_new;
      nxt_pc_m = target;
      flush_m  = redirect;
      ic_m     = (cls == BR_FENCEI);
      dc_m     = (cls == BR_FENCEI);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_random();
    logic [31:0] rs;
    logic [31:0] rb;
    logic [31:0] rc;
    logic [2:0]  slot;
    logic [3:0]  sel;
    logic [2:0]  f3;
    logic [12:0] boff;
    logic [20:0] joff;
    rs   = $random(seed);
    rb   = $random(seed);
    rc   = $random(seed);
    slot = rs[2:0];
    sel  = rs[6:3];
    boff = {rb[12:1], 1'b0};
    joff = {rb[20:1], 1'b0};
    f3   = 3'b000;
    pc   = pc_pool[slot];
    opa  = $random(seed);
    if (rc[0]) begin
      opb = opa;
    end else begin
      opb = $random(seed);
    end
    // Two PCs always repeat one outcome, which drives counters to saturation
    if (slot == 3'd0) begin
      sel = 4'd0;
      opb = opa;
    end else if (slot == 3'd1) begin
      sel = 4'd1;
      opb = opa;
    end
    imm_s = '0;
    case (sel)
      4'd0, 4'd6: cls = BR_BEQ;
      4'd1, 4'd7: cls = BR_BNE;
      4'd2:       cls = BR_BLT;
      4'd3:       cls = BR_BGE;
      4'd4:       cls = BR_BLTU;
      4'd5:       cls = BR_BGEU;
      4'd8, 4'd9: begin
        cls   = BR_JAL;
        insn  = jal_insn(joff);
        imm_s = {{11{joff[20]}}, joff};
      end
      4'd10: begin
        cls  = BR_JALR;
        insn = {rb[31:20], 5'd1, 3'b000, 5'd1, OPC_JALR};
      end
      4'd11: begin
        cls  = BR_FENCEI;
        insn = {rb[31:20], 5'd0, F3_FENCE_I, 5'd0, OPC_MISC_MEM};
      end
      default: begin
        // ALU op, plain FENCE, and branch or JALR with reserved funct3
        cls = BR_NONE;
        case (rb[1:0])
          2'd0:    insn = {rb[31:7], 7'b0110011};
          2'd1:    insn = {rb[31:15], 3'b000, rb[11:7], OPC_MISC_MEM};
          2'd2:    insn = {rb[31:15], 3'b010, rb[11:7], OPC_BRANCH};
          default: insn = {rb[31:15], 3'b100, rb[11:7], OPC_JALR};
        endcase
      end
    endcase
    if (sel < 4'd8) begin
      // funct3 encodings of the six conditional branches
      case (cls)
        BR_BEQ:  f3 = 3'b000;
        BR_BNE:  f3 = 3'b001;
        BR_BLT:  f3 = 3'b100;
        BR_BGE:  f3 = 3'b101;
        BR_BLTU: f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      insn  = branch_insn(f3, boff);
      imm_s = {{19{boff[12]}}, boff};
    end
    bubble = (rc[17:15] == 3'd0);
    if (bubble) cls = BR_NONE;
    exc_in = (rc[10:9] == 2'd0) ? rc[14:11] : 4'h0;
    stall  = (rc[4:2] == 3'd0);
    kill   = (rc[8:5] < 4'd2);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed        = 1;
    cycles      = 0;
    value_errs  = 0;
    other_errs  = 0;
    sat_hi_seen = 1'b0;
    sat_lo_seen = 1'b0;
    fencei_seen = 1'b0;
    mis_seen    = 1'b0;
    pc_pool = '{32'h0000_0100, 32'h0000_0204, 32'h0000_1038, 32'h0000_0490,
                32'h0000_20f0, 32'h0000_0a5c, 32'h0000_3328, 32'h0000_08c4};
    stall  = 1'b0;
    kill   = 1'b0;
    pc     = '0;
    insn   = '0;
    bubble = 1'b1;
    opa    = '0;
    opb    = '0;
    exc_in = '0;
    cls    = BR_NONE;
    imm_s  = '0;
    reset_model();

    // Values while reset is held
    @(negedge clk);
    outputs_vs_model();
    verify_counter("predict_o", 2'b01, predict);

    wait (rst_n === 1'b1);
    repeat (NUM_CYCLES) begin
      advance_model();
      @(posedge clk);
      #1;
      outputs_vs_model();
      drive_random();
      @(negedge clk);
    end

    if (!sat_hi_seen || !sat_lo_seen) begin
      $display("Predictor counters never reached both saturation levels");
      other_errs++;
    end
    if (!fencei_seen || !mis_seen) begin
      $display("Stimulus never produced a FENCE.I or a misaligned target");
      other_errs++;
    end
    $display("Summary: %0d value mismatches, %0d other errors in %0d cycles",
             value_errs, other_errs, NUM_CYCLES);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog over the whole run
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* branch_unit.f */
+incdir+verilog
verilog/bru_pkg.sv
verilog/bru_decode.sv
verilog/bru_resolve.sv
verilog/bru_predictor.sv
verilog/bru_top.sv
verification/tb_clock.sv
verification/tb_bru_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the branch unit testbench with Verilator and runs it.
# The exit status is nonzero when the simulation log reports a failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_bru_top -f branch_unit.f \
  -Mdir obj_dir -o tb_bru_top > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_bru_top > sim.log 2>&1 \
  || { echo "Simulation did not complete"; cat sim.log; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
